//--- hw/pred_geom_pkg.sv
/*
 * Chroma predictor geometry
 * Pixel, edge and block widths, block coordinate width and the
 * constants of the DC engine
 */
package pred_geom_pkg;

    // ----------------------------------------
    // Pixel and block size
    // ----------------------------------------
    localparam int PIX_W = 8;
    localparam int BLK = 8;

    // One packed edge, byte i is pixel i
    localparam int EDGE_W = BLK * PIX_W;

    // One packed 8x8 plane, row major
    localparam int BLOCK_W = BLK * BLK * PIX_W;

    // Block coordinates in units of blocks
    localparam int POS_W = 10;

    // ----------------------------------------
    // DC engine
    // ----------------------------------------
    // Sixteen pixels plus rounding fit in PIX_W + 5 bits
    localparam int SUM_W = PIX_W + 5;
    localparam int DC_SHIFT = 4;
    localparam int DC_DEFAULT = 128;

endpackage

//--- hw/pred_ctrl_pkg.sv
/*
 * Chroma predictor control types
 * Prediction mode encoding and the states of the DC engine and
 * of the request controller
 */
package pred_ctrl_pkg;

    // Mode encoding as seen on mode_i
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_V  = 2'd2,
        MODE_H  = 2'd3
    } pred_mode_e;

    // DC engine, one path state per edge availability
    typedef enum logic [2:0] {
        DC_IDLE,
        DC_BOTH,
        DC_TOP,
        DC_LEFT,
        DC_NONE,
        DC_ROUND
    } dc_state_e;

    typedef enum logic [1:0] {
        CT_IDLE,
        CT_WAIT_DC,
        CT_EMIT
    } ctrl_state_e;

endpackage

//--- hw/pred_edge_if.sv
/*
 * Neighbour edge bundle
 * Top row, left column and corner pixel of the U and V planes
 */
`timescale 1ns/100ps

interface pred_edge_if;

    // Byte c of a top edge is column c
    logic [pred_geom_pkg::EDGE_W-1:0] top_u;
    logic [pred_geom_pkg::EDGE_W-1:0] top_v;

    // Byte r of a left edge is row r
    logic [pred_geom_pkg::EDGE_W-1:0] left_u;
    logic [pred_geom_pkg::EDGE_W-1:0] left_v;

    // Pixel above and left of the block
    logic [pred_geom_pkg::PIX_W-1:0]  corner_u;
    logic [pred_geom_pkg::PIX_W-1:0]  corner_v;

    modport src (
        output top_u, top_v, left_u, left_v, corner_u, corner_v
    );

    modport dst (
        input  top_u, top_v, left_u, left_v, corner_u, corner_v
    );

endinterface

//--- hw/dc_pred_uv.sv
/*
 * Chroma DC engine
 * Walks the available edges one pixel per cycle for U and V, then
 * rounds each sum to a single DC value. A lone edge counts twice,
 * no edge gives the mid-grey default.
 */
`timescale 1ns/100ps

module dc_pred_uv (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    input  logic [pred_geom_pkg::POS_W-1:0]   x_i,
    input  logic [pred_geom_pkg::POS_W-1:0]   y_i,
    pred_edge_if.dst                          edge_if,
    output logic [pred_geom_pkg::PIX_W-1:0]   dc_u_o,
    output logic [pred_geom_pkg::PIX_W-1:0]   dc_v_o,
    output logic                              done_o
);

    typedef logic [pred_geom_pkg::PIX_W-1:0] pix_t;
    typedef logic [pred_geom_pkg::SUM_W-1:0] sum_t;

    pred_ctrl_pkg::dc_state_e state_q;
    pred_ctrl_pkg::dc_state_e state_d;
    logic [3:0] cnt_q;
    sum_t       sum_u_q;
    sum_t       sum_v_q;
    sum_t       add_u;
    sum_t       add_v;
    pix_t       top_u;
    pix_t       top_v;
    pix_t       left_u;
    pix_t       left_v;

    // Add half an LSB of the result before the shift
    function automatic pix_t round_dc(input sum_t sum);
        sum_t rnd;
        rnd = sum_t'(1 << (pred_geom_pkg::DC_SHIFT - 1));
        return pix_t'((sum + rnd) >> pred_geom_pkg::DC_SHIFT);
    endfunction

    // Edge pixels at the current walk position
    assign top_u  = edge_if.top_u[cnt_q[2:0]*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];
    assign top_v  = edge_if.top_v[cnt_q[2:0]*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];
    assign left_u = edge_if.left_u[cnt_q[2:0]*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];
    assign left_v = edge_if.left_v[cnt_q[2:0]*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];

    // ----------------------------------------
    // Path selection
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            pred_ctrl_pkg::DC_IDLE: begin
                if (start_i) begin
                    if (x_i != '0 && y_i != '0) begin
                        state_d = pred_ctrl_pkg::DC_BOTH;
                    end else if (x_i != '0) begin
                        state_d = pred_ctrl_pkg::DC_LEFT;
                    end else if (y_i != '0) begin
                        state_d = pred_ctrl_pkg::DC_TOP;
                    end else begin
                        state_d = pred_ctrl_pkg::DC_NONE;
                    end
                end
            end
            pred_ctrl_pkg::DC_BOTH, pred_ctrl_pkg::DC_TOP, pred_ctrl_pkg::DC_LEFT: begin
                if (cnt_q == 4'(pred_geom_pkg::BLK - 1)) begin
                    state_d = pred_ctrl_pkg::DC_ROUND;
                end
            end
            pred_ctrl_pkg::DC_NONE:  state_d = pred_ctrl_pkg::DC_ROUND;
            pred_ctrl_pkg::DC_ROUND: state_d = pred_ctrl_pkg::DC_IDLE;
            default:                 state_d = pred_ctrl_pkg::DC_IDLE;
        endcase
    end

    // Per-cycle addend, a single edge is weighted by two
    always_comb begin
        add_u = '0;
        add_v = '0;
        case (state_q)
            pred_ctrl_pkg::DC_BOTH: begin
                add_u = sum_t'(top_u) + sum_t'(left_u);
                add_v = sum_t'(top_v) + sum_t'(left_v);
            end
            pred_ctrl_pkg::DC_TOP: begin
                add_u = sum_t'(top_u) << 1;
                add_v = sum_t'(top_v) << 1;
            end
            pred_ctrl_pkg::DC_LEFT: begin
                add_u = sum_t'(left_u) << 1;
                add_v = sum_t'(left_v) << 1;
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // Control and results
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pred_ctrl_pkg::DC_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
            dc_u_o  <= '0;
            dc_v_o  <= '0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == pred_ctrl_pkg::DC_ROUND);
            if (state_q == pred_ctrl_pkg::DC_IDLE) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 4'd1;
            end
            if (state_q == pred_ctrl_pkg::DC_ROUND) begin
                dc_u_o <= round_dc(sum_u_q);
                dc_v_o <= round_dc(sum_v_q);
            end
        end
    end

    // Accumulators, cleared while idle
    always_ff @(posedge clk) begin
        if (state_q == pred_ctrl_pkg::DC_IDLE) begin
            sum_u_q <= '0;
            sum_v_q <= '0;
        end else if (state_q == pred_ctrl_pkg::DC_NONE) begin
            sum_u_q <= sum_t'(pred_geom_pkg::DC_DEFAULT << pred_geom_pkg::DC_SHIFT);
            sum_v_q <= sum_t'(pred_geom_pkg::DC_DEFAULT << pred_geom_pkg::DC_SHIFT);
        end else begin
            sum_u_q <= sum_u_q + add_u;
            sum_v_q <= sum_v_q + add_v;
        end
    end

endmodule

//--- hw/pred_fill_uv.sv
/*
 * Chroma block builder
 * Forms both 8x8 predicted planes for DC, V, H and TrueMotion.
 * Purely combinational, driven by the latched mode.
 */
`timescale 1ns/100ps

module pred_fill_uv (
    input  pred_ctrl_pkg::pred_mode_e           mode_i,
    input  logic [pred_geom_pkg::PIX_W-1:0]     dc_u_i,
    input  logic [pred_geom_pkg::PIX_W-1:0]     dc_v_i,
    pred_edge_if.dst                            edge_if,
    output logic [pred_geom_pkg::BLOCK_W-1:0]   block_u_o,
    output logic [pred_geom_pkg::BLOCK_W-1:0]   block_v_o
);

    typedef logic [pred_geom_pkg::PIX_W-1:0]   pix_t;
    typedef logic [pred_geom_pkg::EDGE_W-1:0]  edge_t;
    typedef logic [pred_geom_pkg::BLOCK_W-1:0] plane_t;
    typedef logic signed [pred_geom_pkg::PIX_W+1:0] tm_t;

    // Saturate a TrueMotion term to the pixel range
    function automatic pix_t clamp_pix(input tm_t val);
        pix_t res;
        if (val < 0) begin
            res = '0;
        end else if (val > tm_t'(255)) begin
            res = '1;
        end else begin
            res = val[pred_geom_pkg::PIX_W-1:0];
        end
        return res;
    endfunction

    function automatic plane_t fill_plane(
        input pred_ctrl_pkg::pred_mode_e mode,
        input pix_t                      dc,
        input edge_t                     top,
        input edge_t                     left,
        input pix_t                      corner
    );
        plane_t plane;
        pix_t   top_px;
        pix_t   left_px;
        pix_t   px;
        tm_t    tm;
        plane = '0;
        for (int r = 0; r < pred_geom_pkg::BLK; r++) begin
            for (int c = 0; c < pred_geom_pkg::BLK; c++) begin
                top_px  = top[c*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];
                left_px = left[r*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W];
                // Left plus top minus corner, in signed 10 bits
                tm = $signed({2'b00, left_px}) + $signed({2'b00, top_px})
                     - $signed({2'b00, corner});
                case (mode)
                    pred_ctrl_pkg::MODE_V:  px = top_px;
                    pred_ctrl_pkg::MODE_H:  px = left_px;
                    pred_ctrl_pkg::MODE_TM: px = clamp_pix(tm);
                    default:                px = dc;
                endcase
                plane[(r*pred_geom_pkg::BLK + c)*pred_geom_pkg::PIX_W +: pred_geom_pkg::PIX_W] = px;
            end
        end
        return plane;
    endfunction

    // ----------------------------------------
    // U and V planes
    // ----------------------------------------
    assign block_u_o = fill_plane(mode_i, dc_u_i, edge_if.top_u, edge_if.left_u,
                                  edge_if.corner_u);
    assign block_v_o = fill_plane(mode_i, dc_v_i, edge_if.top_v, edge_if.left_v,
                                  edge_if.corner_v);

endmodule

//--- hw/pred_mode_ctrl.sv
/*
 * Chroma prediction request controller
 * Accepts one request while idle, latches its mode, runs the DC
 * engine for DC requests and registers the finished planes with
 * a one-cycle done pulse.
 */
`timescale 1ns/100ps

module pred_mode_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start_i,
    input  pred_ctrl_pkg::pred_mode_e            mode_i,
    input  logic                                 dc_done_i,
    input  logic [pred_geom_pkg::BLOCK_W-1:0]    block_u_i,
    input  logic [pred_geom_pkg::BLOCK_W-1:0]    block_v_i,
    output logic                                 dc_start_o,
    output pred_ctrl_pkg::pred_mode_e            mode_o,
    output logic                                 busy_o,
    output logic                                 done_o,
    output logic [2*pred_geom_pkg::BLOCK_W-1:0]  dst_o
);

    pred_ctrl_pkg::ctrl_state_e state_q;
    pred_ctrl_pkg::ctrl_state_e state_d;
    logic                       accept;

    // Busy until the done cycle has passed
    assign busy_o = (state_q != pred_ctrl_pkg::CT_IDLE) || done_o;
    assign accept = start_i && !busy_o;

    // Same cycle as the accepted start, so the engine samples x and y then
    assign dc_start_o = accept && (mode_i == pred_ctrl_pkg::MODE_DC);

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            pred_ctrl_pkg::CT_IDLE: begin
                if (accept) begin
                    if (mode_i == pred_ctrl_pkg::MODE_DC) begin
                        state_d = pred_ctrl_pkg::CT_WAIT_DC;
                    end else begin
                        state_d = pred_ctrl_pkg::CT_EMIT;
                    end
                end
            end
            pred_ctrl_pkg::CT_WAIT_DC: begin
                if (dc_done_i) begin
                    state_d = pred_ctrl_pkg::CT_EMIT;
                end
            end
            pred_ctrl_pkg::CT_EMIT: state_d = pred_ctrl_pkg::CT_IDLE;
            default:                state_d = pred_ctrl_pkg::CT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pred_ctrl_pkg::CT_IDLE;
            mode_o  <= pred_ctrl_pkg::MODE_DC;
            done_o  <= 1'b0;
            dst_o   <= '0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == pred_ctrl_pkg::CT_EMIT);
            if (accept) begin
                mode_o <= mode_i;
            end
            // V plane in the upper half
            if (state_q == pred_ctrl_pkg::CT_EMIT) begin
                dst_o <= {block_v_i, block_u_i};
            end
        end
    end

endmodule

//--- hw/chroma_pred_top.sv
/*
 * Chroma intra predictor top level
 * One 8x8 U and one 8x8 V block per request in DC, V, H or
 * TrueMotion mode. Edges stay stable from start to done.
 */
`timescale 1ns/100ps

module chroma_pred_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start_i,
    input  logic [1:0]                           mode_i,
    input  logic [pred_geom_pkg::POS_W-1:0]      x_i,
    input  logic [pred_geom_pkg::POS_W-1:0]      y_i,
    input  logic [pred_geom_pkg::EDGE_W-1:0]     top_u_i,
    input  logic [pred_geom_pkg::EDGE_W-1:0]     top_v_i,
    input  logic [pred_geom_pkg::EDGE_W-1:0]     left_u_i,
    input  logic [pred_geom_pkg::EDGE_W-1:0]     left_v_i,
    input  logic [pred_geom_pkg::PIX_W-1:0]      corner_u_i,
    input  logic [pred_geom_pkg::PIX_W-1:0]      corner_v_i,
    output logic                                 busy_o,
    output logic                                 done_o,
    output logic [2*pred_geom_pkg::BLOCK_W-1:0]  dst_o
);

    logic                              dc_start;
    logic                              dc_done;
    logic [pred_geom_pkg::PIX_W-1:0]   dc_u;
    logic [pred_geom_pkg::PIX_W-1:0]   dc_v;
    logic [pred_geom_pkg::BLOCK_W-1:0] block_u;
    logic [pred_geom_pkg::BLOCK_W-1:0] block_v;
    pred_ctrl_pkg::pred_mode_e         mode;

    // Edge bus fed from the pins
    pred_edge_if edge_bus ();

    assign edge_bus.top_u    = top_u_i;
    assign edge_bus.top_v    = top_v_i;
    assign edge_bus.left_u   = left_u_i;
    assign edge_bus.left_v   = left_v_i;
    assign edge_bus.corner_u = corner_u_i;
    assign edge_bus.corner_v = corner_v_i;

    pred_mode_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .mode_i     (pred_ctrl_pkg::pred_mode_e'(mode_i)),
        .dc_done_i  (dc_done),
        .block_u_i  (block_u),
        .block_v_i  (block_v),
        .dc_start_o (dc_start),
        .mode_o     (mode),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .dst_o      (dst_o)
    );

    dc_pred_uv u_dc (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (dc_start),
        .x_i     (x_i),
        .y_i     (y_i),
        .edge_if (edge_bus),
        .dc_u_o  (dc_u),
        .dc_v_o  (dc_v),
        .done_o  (dc_done)
    );

    pred_fill_uv u_fill (
        .mode_i    (mode),
        .dc_u_i    (dc_u),
        .dc_v_i    (dc_v),
        .edge_if   (edge_bus),
        .block_u_o (block_u),
        .block_v_o (block_v)
    );

endmodule

//--- testbench/chroma_pred_chk.sv
/*
 * Chroma predictor handshake checker
 * Concurrent assertions on start, busy, done and the held result,
 * bound into the top level
 */
`timescale 1ns/100ps

module chroma_pred_chk (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                start_i,
    input logic                                busy_o,
    input logic                                done_o,
    input logic [2*pred_geom_pkg::BLOCK_W-1:0] dst_o
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else begin
            $error("done_o high for more than one cycle");
            fail_count++;
        end

    // Done only closes a request that was already busy
    done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> $past(busy_o))
        else begin
            $error("done_o seen without busy_o high in the cycle before");
            fail_count++;
        end

    // Result holds between requests
    dst_held_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy_o && !done_o) |-> $stable(dst_o))
        else begin
            $error("dst_o changed while idle");
            fail_count++;
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start_i && !busy_o) |=> busy_o)
        else begin
            $error("busy_o did not rise after an accepted start");
            fail_count++;
        end

endmodule

bind chroma_pred_top chroma_pred_chk chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .dst_o   (dst_o)
);

//--- testbench/tb_chroma_pred.sv
/*
 * Chroma intra predictor testbench
 * Directed DC, V, H and TrueMotion requests on random and extreme
 * edges, checked byte by byte against a reference model
 */
`timescale 1ns/100ps

module tb_chroma_pred;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int DONE_LIMIT   = 16;
    localparam int NUM_TESTS    = 10;

    logic          clk;
    logic          rst_n;
    logic          start_i;
    logic [1:0]    mode_i;
    logic [9:0]    x_i;
    logic [9:0]    y_i;
    logic [63:0]   top_u_i;
    logic [63:0]   top_v_i;
    logic [63:0]   left_u_i;
    logic [63:0]   left_v_i;
    logic [7:0]    corner_u_i;
    logic [7:0]    corner_v_i;
    logic          busy_o;
    logic          done_o;
    logic [1023:0] dst_o;

    int seed;
    int errors;
    int checks;

    chroma_pred_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [511:0] model_plane(
        input pred_ctrl_pkg::pred_mode_e mode,
        input logic [9:0]                x,
        input logic [9:0]                y,
        input logic [63:0]               top,
        input logic [63:0]               left,
        input logic [7:0]                corner
    );
        logic [511:0] plane;
        int           sum_top;
        int           sum_left;
        int           dc;
        int           tp;
        int           lp;
        int           v;
        sum_top  = 0;
        sum_left = 0;
        for (int i = 0; i < 8; i++) begin
            sum_top  += int'(top[i*8 +: 8]);
            sum_left += int'(left[i*8 +: 8]);
        end
        // x picks the left edge, y the top edge
        if (x != '0 && y != '0) begin
            dc = (sum_top + sum_left + 8) >> 4;
        end else if (y != '0) begin
            dc = (2 * sum_top + 8) >> 4;
        end else if (x != '0) begin
            dc = (2 * sum_left + 8) >> 4;
        end else begin
            dc = 128;
        end
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                tp = int'(top[c*8 +: 8]);
                lp = int'(left[r*8 +: 8]);
                case (mode)
                    pred_ctrl_pkg::MODE_V:  v = tp;
                    pred_ctrl_pkg::MODE_H:  v = lp;
                    pred_ctrl_pkg::MODE_TM: begin
                        v = lp + tp - int'(corner);
                        if (v < 0) v = 0;
                        if (v > 255) v = 255;
                    end
                    default: v = dc;
                endcase
                plane[(r*8 + c)*8 +: 8] = 8'(v);
            end
        end
        return plane;
    endfunction

    // ----------------------------------------
    // Stimulus and checking helpers
    // ----------------------------------------
    task automatic set_random_edges();
        logic [31:0] rnd;
        @(negedge clk);
        top_u_i  = {$random(seed), $random(seed)};
        top_v_i  = {$random(seed), $random(seed)};
        left_u_i = {$random(seed), $random(seed)};
        left_v_i = {$random(seed), $random(seed)};
        rnd = $random(seed);
        corner_u_i = rnd[7:0];
        corner_v_i = rnd[15:8];
    endtask

    task automatic issue_start(input pred_ctrl_pkg::pred_mode_e mode,
                               input logic [9:0] x, input logic [9:0] y);
        @(negedge clk);
        start_i = 1'b1;
        mode_i  = mode;
        x_i     = x;
        y_i     = y;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        while (done_o !== 1'b1 && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (done_o === 1'b1) else begin
            $display("Timeout: %s got no done_o within %0d cycles", name, DONE_LIMIT);
            errors++;
        end
    endtask

    task automatic compare_result(input string name, input logic [1023:0] exp);
        for (int b = 0; b < 128; b++) begin
            checks++;
            assert (dst_o[b*8 +: 8] === exp[b*8 +: 8]) else begin
                $display("** Error at %0t ns: %s byte %0d is %0d, expected %0d",
                         $time, name, b, dst_o[b*8 +: 8], exp[b*8 +: 8]);
                errors++;
            end
        end
    endtask

    task automatic run_request(input string name, input pred_ctrl_pkg::pred_mode_e mode,
                               input logic [9:0] x, input logic [9:0] y);
        logic [1023:0] exp;
        exp = {model_plane(mode, x, y, top_v_i, left_v_i, corner_v_i),
               model_plane(mode, x, y, top_u_i, left_u_i, corner_u_i)};
        issue_start(mode, x, y);
        wait_done(name);
        compare_result(name, exp);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_state();
        checks++;
        assert (busy_o === 1'b0 && done_o === 1'b0 && dst_o === '0) else begin
            $display("** Error at %0t ns: outputs not idle after reset", $time);
            errors++;
        end
    endtask

    task automatic dc_both_edges();
        set_random_edges();
        run_request("DC both edges", pred_ctrl_pkg::MODE_DC, 10'd3, 10'd2);
    endtask

    task automatic dc_single_or_no_edge();
        set_random_edges();
        run_request("DC top edge", pred_ctrl_pkg::MODE_DC, 10'd0, 10'd4);
        run_request("DC left edge", pred_ctrl_pkg::MODE_DC, 10'd5, 10'd0);
        run_request("DC no edge", pred_ctrl_pkg::MODE_DC, 10'd0, 10'd0);
    endtask

    task automatic copy_modes();
        set_random_edges();
        run_request("V copy", pred_ctrl_pkg::MODE_V, 10'd1, 10'd1);
        run_request("H copy", pred_ctrl_pkg::MODE_H, 10'd1, 10'd1);
    endtask

    task automatic true_motion_clamp();
        set_random_edges();
        run_request("TM random", pred_ctrl_pkg::MODE_TM, 10'd2, 10'd6);
        // U falls below 0 everywhere, V rises above 255 everywhere
        @(negedge clk);
        top_u_i    = top_u_i & 64'h3f3f_3f3f_3f3f_3f3f;
        left_u_i   = left_u_i & 64'h3f3f_3f3f_3f3f_3f3f;
        corner_u_i = 8'hff;
        top_v_i    = top_v_i | 64'hc0c0_c0c0_c0c0_c0c0;
        left_v_i   = left_v_i | 64'hc0c0_c0c0_c0c0_c0c0;
        corner_v_i = 8'h00;
        run_request("TM clamp", pred_ctrl_pkg::MODE_TM, 10'd2, 10'd6);
    endtask

    task automatic ignore_start_while_busy();
        logic [1023:0] exp;
        int            extra;
        set_random_edges();
        exp = {model_plane(pred_ctrl_pkg::MODE_DC, 10'd2, 10'd7, top_v_i, left_v_i, corner_v_i),
               model_plane(pred_ctrl_pkg::MODE_DC, 10'd2, 10'd7, top_u_i, left_u_i, corner_u_i)};
        issue_start(pred_ctrl_pkg::MODE_DC, 10'd2, 10'd7);
        repeat (2) @(negedge clk);
        assert (busy_o === 1'b1) else begin
            $display("** Error at %0t ns: busy_o low during a DC request", $time);
            errors++;
        end
        // Second request lands mid-run
        start_i = 1'b1;
        mode_i  = pred_ctrl_pkg::MODE_H;
        x_i     = 10'd0;
        y_i     = 10'd0;
        @(negedge clk);
        start_i = 1'b0;
        wait_done("busy ignore");
        compare_result("busy ignore", exp);
        extra = 0;
        repeat (DONE_LIMIT) begin
            @(negedge clk);
            if (done_o) extra++;
        end
        assert (extra == 0) else begin
            $display("** Error at %0t ns: %0d extra done_o pulses after ignored start",
                     $time, extra);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    initial begin
        #((NUM_TESTS * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed       = 22;
        errors     = 0;
        checks     = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start_i    = 1'b0;
        mode_i     = '0;
        x_i        = '0;
        y_i        = '0;
        top_u_i    = '0;
        top_v_i    = '0;
        left_u_i   = '0;
        left_v_i   = '0;
        corner_u_i = '0;
        corner_v_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        dc_both_edges();
        dc_single_or_no_edge();
        copy_modes();
        true_motion_clamp();
        ignore_start_while_busy();

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.chk.fail_count);
        if (errors == 0 && uut.chk.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
hw/pred_geom_pkg.sv
hw/pred_ctrl_pkg.sv
hw/pred_edge_if.sv
hw/dc_pred_uv.sv
hw/pred_fill_uv.sv
hw/pred_mode_ctrl.sv
hw/chroma_pred_top.sv
testbench/chroma_pred_chk.sv
testbench/tb_chroma_pred.sv

//--- Makefile
# Verilator build and run of the chroma predictor testbench
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_chroma_pred
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
